/* lumi_pkg.sv */
/*
 * LUMI transmit shared definitions
 * Field widths and types, command field positions, opcodes
 * Byte counts, channel tags and credit message layout
 */
package lumi_pkg;

   // ################################################
   // Widths
   // ################################################
   localparam int cw      = 32;               // Command word
   localparam int aw      = 64;               // Each address
   localparam int dw      = 128;              // Data
   localparam int iow     = 64;               // PHY lane, 8 bytes
   localparam int pkt_w   = cw + 2*aw + dw;   // Whole packet, 288 bits
   localparam int crdt_w  = 16;               // Credit counters
   localparam int bytes_w = 12;               // Byte counts

   typedef logic [crdt_w-1:0]  crdt_t;
   typedef logic [bytes_w-1:0] bytes_t;
   typedef logic [pkt_w-1:0]   pkt_t;

   // Byte counts on the lane
   localparam bytes_t cmd_bytes      = bytes_t'(cw / 8);           // Command only
   localparam bytes_t hdr_bytes      = bytes_t'((cw + 2*aw) / 8);  // Command plus addresses
   localparam bytes_t data_bytes_max = bytes_t'(dw / 8);

   // ################################################
   // Command word
   // ################################################
   localparam int opc_lsb  = 0;
   localparam int opc_w    = 8;
   localparam int size_lsb = 8;
   localparam int size_w   = 3;
   localparam int len_lsb  = 16;
   localparam int len_w    = 8;

   localparam logic [opc_w-1:0] op_invalid    = 8'h00;
   localparam logic [opc_w-1:0] op_read       = 8'h01;
   localparam logic [opc_w-1:0] op_write      = 8'h03;
   localparam logic [opc_w-1:0] op_posted     = 8'h05;
   localparam logic [opc_w-1:0] op_rdma       = 8'h07;
   localparam logic [opc_w-1:0] op_user0      = 8'h0B;
   localparam logic [opc_w-1:0] op_future0    = 8'h0D;
   localparam logic [opc_w-1:0] op_error      = 8'h0F;
   localparam logic [opc_w-1:0] op_write_resp = 8'h04;
   localparam logic [opc_w-1:0] op_link       = 8'h2F;

   // ################################################
   // Credit messages and channel tags
   // ################################################
   localparam logic [3:0] crdt_msg_type = 4'h2;   // Bits 11:8 of a credit message
   localparam logic [3:0] chan_req      = 4'h0;   // Channel code, bits 15:12
   localparam logic [3:0] chan_resp     = 4'h1;

   // Tag of the packet held in the serializer
   localparam logic [1:0] tag_none = 2'd0;        // Credit message, no credit used
   localparam logic [1:0] tag_req  = 2'd1;
   localparam logic [1:0] tag_resp = 2'd2;

endpackage

/* lumi_cmd_decode.sv */
/*
 * Packet length reduction
 * Byte count of one packet from opcode, size and len
 */
module lumi_cmd_decode (
   input  logic [lumi_pkg::cw-1:0] cmd,
   output lumi_pkg::bytes_t        packet_bytes   // Bytes actually sent
);

   logic [lumi_pkg::opc_w-1:0]  opcode;
   logic [lumi_pkg::size_w-1:0] size;
   logic [lumi_pkg::len_w-1:0]  len;
   logic [15:0]                 data_full;        // Untrimmed payload bytes
   lumi_pkg::bytes_t            data_bytes;

   assign opcode = cmd[lumi_pkg::opc_lsb +: lumi_pkg::opc_w];
   assign size   = cmd[lumi_pkg::size_lsb +: lumi_pkg::size_w];
   assign len    = cmd[lumi_pkg::len_lsb +: lumi_pkg::len_w];

   // (len+1) words of 2^size bytes, 256 << 7 still fits in 16 bits
   assign data_full = (16'(len) + 16'd1) << size;

   // Payload never beyond the data field
   assign data_bytes = (data_full > 16'(lumi_pkg::data_bytes_max)) ?
                       lumi_pkg::data_bytes_max :
                       data_full[lumi_pkg::bytes_w-1:0];

   always_comb
   begin
      case (opcode)
         lumi_pkg::op_invalid,
         lumi_pkg::op_link:
            packet_bytes = lumi_pkg::cmd_bytes;    // Command word only
         lumi_pkg::op_read,
         lumi_pkg::op_rdma,
         lumi_pkg::op_error,
         lumi_pkg::op_write_resp,
         lumi_pkg::op_user0,
         lumi_pkg::op_future0:
            packet_bytes = lumi_pkg::hdr_bytes;    // No data
         default:
            packet_bytes = lumi_pkg::hdr_bytes + data_bytes;  // Writes, posted, read data
      endcase
   end

endmodule

/* lumi_tx_credit.sv */
/*
 * Transmit credit management
 * Sent-beat counters and credit checks per channel
 * Stall counters and credit-update interval timer
 */
module lumi_tx_credit (
   input  logic                          clk,
   input  logic                          nreset,
   input  logic                          csr_crdt_en,      // Enable periodic updates
   input  lumi_pkg::crdt_t               csr_crdt_intrvl,  // Update interval in cycles
   input  logic [7:0]                    csr_iowidth,      // Lane bytes, 1/2/4/8
   input  lumi_pkg::crdt_t               rmt_crdt_req,     // Cumulative remote credits
   input  lumi_pkg::crdt_t               rmt_crdt_resp,
   input  lumi_pkg::bytes_t              req_bytes,
   input  lumi_pkg::bytes_t              resp_bytes,
   input  logic                          req_valid,
   input  logic                          resp_valid,
   input  logic                          phy_txrdy,
   input  logic                          beat_req,         // One pulse per sent beat
   input  logic                          beat_resp,
   input  logic                          crdt_sent,        // Credit message loaded
   output logic                          req_crdt_ok,
   output logic                          resp_crdt_ok,
   output logic [1:0]                    crdt_updt_send,   // Bit 0 resp msg, bit 1 req msg
   output logic [2*lumi_pkg::crdt_w-1:0] csr_crdt_status   // Resp stalls high, req low
);

   logic [1:0]      io_shift;         // log2 of lane bytes
   lumi_pkg::crdt_t req_need;         // Beats the waiting packet needs
   lumi_pkg::crdt_t resp_need;
   lumi_pkg::crdt_t tx_crdt_req;      // Beats sent so far
   lumi_pkg::crdt_t tx_crdt_resp;
   lumi_pkg::crdt_t crdt_updt_cntr;

   always_comb
   begin
      case (csr_iowidth)
         8'd2:    io_shift = 2'd1;
         8'd4:    io_shift = 2'd2;
         8'd8:    io_shift = 2'd3;
         default: io_shift = 2'd0;    // Single byte lane
      endcase
   end

   // ################################################
   // Credit checks
   // ################################################
   // Rounded up to whole beats
   assign req_need  = (lumi_pkg::crdt_t'(req_bytes) + lumi_pkg::crdt_t'(csr_iowidth)
                       - 1'b1) >> io_shift;
   assign resp_need = (lumi_pkg::crdt_t'(resp_bytes) + lumi_pkg::crdt_t'(csr_iowidth)
                       - 1'b1) >> io_shift;

   // Difference wraps modulo 2^16 with the remote count
   assign req_crdt_ok  = lumi_pkg::crdt_t'(rmt_crdt_req - tx_crdt_req) >= req_need;
   assign resp_crdt_ok = lumi_pkg::crdt_t'(rmt_crdt_resp - tx_crdt_resp) >= resp_need;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         tx_crdt_req     <= '0;
         tx_crdt_resp    <= '0;
         csr_crdt_status <= '0;
      end
      else
      begin
         if (beat_req)
            tx_crdt_req <= tx_crdt_req + 1'b1;
         if (beat_resp)
            tx_crdt_resp <= tx_crdt_resp + 1'b1;
         // Stall cycles, ready to go but short of credit
         if (req_valid && phy_txrdy && !req_crdt_ok)
            csr_crdt_status[15:0] <= csr_crdt_status[15:0] + 1'b1;
         if (resp_valid && phy_txrdy && !resp_crdt_ok)
            csr_crdt_status[31:16] <= csr_crdt_status[31:16] + 1'b1;
      end
   end

   // ################################################
   // Credit-update timer
   // ################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         crdt_updt_cntr <= '0;
         crdt_updt_send <= 2'b00;
      end
      else
      begin
         if (csr_crdt_en)
            crdt_updt_cntr <= (crdt_updt_cntr == csr_crdt_intrvl) ? '0 : crdt_updt_cntr + 1'b1;
         if (csr_crdt_en && (crdt_updt_cntr == csr_crdt_intrvl))
            crdt_updt_send <= 2'b01;                     // Response message first
         else if (crdt_sent)
            crdt_updt_send <= {crdt_updt_send[0], 1'b0}; // Then request, then done
      end
   end

   // One message pending at a time
   a_updt_onehot: assert property (@(posedge clk) disable iff (!nreset)
      crdt_updt_send != 2'b11);

endmodule

/* lumi_tx_arbiter.sv */
/*
 * Transmit arbiter
 * Credit message over response over request
 * Packet assembly, serializer load and input readies
 */
module lumi_tx_arbiter (
   input  logic                    req_valid,
   input  logic [lumi_pkg::cw-1:0] req_cmd,
   input  logic [lumi_pkg::aw-1:0] req_dstaddr,
   input  logic [lumi_pkg::aw-1:0] req_srcaddr,
   input  logic [lumi_pkg::dw-1:0] req_data,
   input  logic                    resp_valid,
   input  logic [lumi_pkg::cw-1:0] resp_cmd,
   input  logic [lumi_pkg::aw-1:0] resp_dstaddr,
   input  logic [lumi_pkg::aw-1:0] resp_srcaddr,
   input  logic [lumi_pkg::dw-1:0] resp_data,
   input  lumi_pkg::crdt_t         loc_crdt_req,    // Local credits to advertise
   input  lumi_pkg::crdt_t         loc_crdt_resp,
   input  logic                    csr_en,
   input  logic                    phy_txrdy,       // Gates packet start only
   input  logic                    ser_ready,       // Empty or in last beat
   input  logic                    req_crdt_ok,
   input  logic                    resp_crdt_ok,
   input  logic [1:0]              crdt_updt_send,
   output logic                    req_ready,
   output logic                    resp_ready,
   output lumi_pkg::bytes_t        req_bytes,
   output lumi_pkg::bytes_t        resp_bytes,
   output logic                    load,            // Single-cycle strobe
   output lumi_pkg::pkt_t          load_data,
   output lumi_pkg::bytes_t        load_bytes,
   output logic [1:0]              load_chan,
   output logic                    crdt_sent
);

   logic                    msg_pend;     // A credit message waits
   logic                    start_ok;     // Serializer and PHY can take a packet
   logic                    resp_elig;
   logic                    req_elig;
   logic [lumi_pkg::cw-1:0] msg_cmd;

   // Trimmed lengths for packing and credit checks
   lumi_cmd_decode decode_req (
      .cmd          (req_cmd),
      .packet_bytes (req_bytes)
   );

   lumi_cmd_decode decode_resp (
      .cmd          (resp_cmd),
      .packet_bytes (resp_bytes)
   );

   // ################################################
   // Selection
   // ################################################
   assign msg_pend  = |crdt_updt_send;
   assign start_ok  = ser_ready & csr_en & phy_txrdy;
   assign resp_elig = resp_valid & resp_crdt_ok & ~msg_pend;  // Blocked by credit messages
   assign req_elig  = req_valid & req_crdt_ok & ~msg_pend;

   assign load       = start_ok & (msg_pend | resp_elig | req_elig);
   assign crdt_sent  = start_ok & msg_pend;
   assign resp_ready = start_ok & resp_elig;
   assign req_ready  = start_ok & req_elig & ~resp_elig;       // Response wins

   // Link message carrying local credits
   assign msg_cmd = crdt_updt_send[0] ?
                    {loc_crdt_resp, lumi_pkg::chan_resp, lumi_pkg::crdt_msg_type,
                     lumi_pkg::op_link} :
                    {loc_crdt_req, lumi_pkg::chan_req, lumi_pkg::crdt_msg_type,
                     lumi_pkg::op_link};

   // ################################################
   // Packet assembly with cmd in the low bits
   // ################################################
   always_comb
   begin
      load_data  = {req_data, req_srcaddr, req_dstaddr, req_cmd};
      load_bytes = req_bytes;
      load_chan  = lumi_pkg::tag_none;
      if (msg_pend)
      begin
         load_data  = lumi_pkg::pkt_t'(msg_cmd);    // Command only
         load_bytes = lumi_pkg::cmd_bytes;
      end
      else if (resp_elig)
      begin
         load_data  = {resp_data, resp_srcaddr, resp_dstaddr, resp_cmd};
         load_bytes = resp_bytes;
         load_chan  = lumi_pkg::tag_resp;
      end
      else if (req_elig)
         load_chan = lumi_pkg::tag_req;
   end

   // One input channel granted at a time
   always_comb
   begin
      a_one_ready: assert (!(req_ready && resp_ready));
   end

endmodule

/* lumi_tx_serializer.sv */
/*
 * Transmit serializer
 * Packet shift register, remaining-byte count and channel tag
 */
module lumi_tx_serializer (
   input  logic                     clk,
   input  logic                     nreset,
   input  logic [7:0]               csr_iowidth,  // Bytes per beat
   input  logic                     load,
   input  lumi_pkg::pkt_t           load_data,
   input  lumi_pkg::bytes_t         load_bytes,
   input  logic [1:0]               load_chan,
   output logic                     ser_ready,
   output logic [lumi_pkg::iow-1:0] phy_txdata,
   output logic                     phy_txvld,
   output logic                     beat_req,     // Beat of a request packet
   output logic                     beat_resp
);

   lumi_pkg::pkt_t   shreg;      // LSB goes out first
   lumi_pkg::bytes_t remain;     // Bytes not yet on the lane
   lumi_pkg::bytes_t step;       // Bytes per beat
   logic [1:0]       chan;       // Owner of the current packet
   logic             last_beat;

   assign step      = lumi_pkg::bytes_t'(csr_iowidth);
   assign phy_txvld = remain != '0;
   assign last_beat = phy_txvld && (remain <= step);
   assign ser_ready = !phy_txvld || last_beat;   // Next packet follows with no gap

   assign phy_txdata = shreg[lumi_pkg::iow-1:0];
   assign beat_req   = phy_txvld && (chan == lumi_pkg::tag_req);
   assign beat_resp  = phy_txvld && (chan == lumi_pkg::tag_resp);

   // ################################################
   // Control state
   // ################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         remain <= '0;
         chan   <= lumi_pkg::tag_none;
      end
      else if (load)
      begin
         remain <= load_bytes;
         chan   <= load_chan;
      end
      else if (phy_txvld)
         remain <= last_beat ? '0 : remain - step;   // Streams regardless of phy_txrdy
   end

   // Payload, shifted down one beat per cycle
   always_ff @(posedge clk)
   begin
      if (load)
         shreg <= load_data;
      else if (phy_txvld)
         shreg <= shreg >> {csr_iowidth, 3'b000};
   end

   a_load_ready: assert property (@(posedge clk) disable iff (!nreset)
      load |-> ser_ready);

endmodule

/* lumi_tx.sv */
/*
 * LUMI transmit top level
 * Arbiter, credit block and serializer on one PHY lane
 */
module lumi_tx (
   input  logic                          clk,
   input  logic                          nreset,
   // Control
   input  logic                          csr_en,           // Enable transmit
   input  logic                          csr_crdt_en,      // Enable credit updates
   input  logic [7:0]                    csr_iowidth,      // Lane bytes, 1/2/4/8
   input  lumi_pkg::crdt_t               csr_crdt_intrvl,
   output logic [2*lumi_pkg::crdt_w-1:0] csr_crdt_status,
   // Request channel
   input  logic                          req_valid,
   input  logic [lumi_pkg::cw-1:0]       req_cmd,
   input  logic [lumi_pkg::aw-1:0]       req_dstaddr,
   input  logic [lumi_pkg::aw-1:0]       req_srcaddr,
   input  logic [lumi_pkg::dw-1:0]       req_data,
   output logic                          req_ready,
   // Response channel
   input  logic                          resp_valid,
   input  logic [lumi_pkg::cw-1:0]       resp_cmd,
   input  logic [lumi_pkg::aw-1:0]       resp_dstaddr,
   input  logic [lumi_pkg::aw-1:0]       resp_srcaddr,
   input  logic [lumi_pkg::dw-1:0]       resp_data,
   output logic                          resp_ready,
   // PHY lane
   output logic [lumi_pkg::iow-1:0]      phy_txdata,
   output logic                          phy_txvld,
   input  logic                          phy_txrdy,
   // Credits
   input  lumi_pkg::crdt_t               rmt_crdt_req,     // Granted by the far side
   input  lumi_pkg::crdt_t               rmt_crdt_resp,
   input  lumi_pkg::crdt_t               loc_crdt_req,     // Advertised to the far side
   input  lumi_pkg::crdt_t               loc_crdt_resp
);

   lumi_pkg::bytes_t req_bytes;
   lumi_pkg::bytes_t resp_bytes;
   lumi_pkg::pkt_t   load_data;
   lumi_pkg::bytes_t load_bytes;
   logic [1:0]       load_chan;
   logic [1:0]       crdt_updt_send;
   logic             load;
   logic             ser_ready;
   logic             req_crdt_ok;
   logic             resp_crdt_ok;
   logic             crdt_sent;
   logic             beat_req;
   logic             beat_resp;

   lumi_tx_arbiter arbiter (
      .req_valid      (req_valid),      .req_cmd       (req_cmd),
      .req_dstaddr    (req_dstaddr),    .req_srcaddr   (req_srcaddr),
      .req_data       (req_data),       .resp_valid    (resp_valid),
      .resp_cmd       (resp_cmd),       .resp_dstaddr  (resp_dstaddr),
      .resp_srcaddr   (resp_srcaddr),   .resp_data     (resp_data),
      .loc_crdt_req   (loc_crdt_req),   .loc_crdt_resp (loc_crdt_resp),
      .csr_en         (csr_en),         .phy_txrdy     (phy_txrdy),
      .ser_ready      (ser_ready),      .req_crdt_ok   (req_crdt_ok),
      .resp_crdt_ok   (resp_crdt_ok),   .crdt_updt_send(crdt_updt_send),
      .req_ready      (req_ready),      .resp_ready    (resp_ready),
      .req_bytes      (req_bytes),      .resp_bytes    (resp_bytes),
      .load           (load),           .load_data     (load_data),
      .load_bytes     (load_bytes),     .load_chan     (load_chan),
      .crdt_sent      (crdt_sent)
   );

   lumi_tx_credit credit (
      .clk            (clk),            .nreset          (nreset),
      .csr_crdt_en    (csr_crdt_en),    .csr_crdt_intrvl (csr_crdt_intrvl),
      .csr_iowidth    (csr_iowidth),    .rmt_crdt_req    (rmt_crdt_req),
      .rmt_crdt_resp  (rmt_crdt_resp),  .req_bytes       (req_bytes),
      .resp_bytes     (resp_bytes),     .req_valid       (req_valid),
      .resp_valid     (resp_valid),     .phy_txrdy       (phy_txrdy),
      .beat_req       (beat_req),       .beat_resp       (beat_resp),
      .crdt_sent      (crdt_sent),      .req_crdt_ok     (req_crdt_ok),
      .resp_crdt_ok   (resp_crdt_ok),   .crdt_updt_send  (crdt_updt_send),
      .csr_crdt_status(csr_crdt_status)
   );

   lumi_tx_serializer serializer (
      .clk         (clk),          .nreset     (nreset),
      .csr_iowidth (csr_iowidth),  .load       (load),
      .load_data   (load_data),    .load_bytes (load_bytes),
      .load_chan   (load_chan),    .ser_ready  (ser_ready),
      .phy_txdata  (phy_txdata),   .phy_txvld  (phy_txvld),
      .beat_req    (beat_req),     .beat_resp  (beat_resp)
   );

endmodule

/* tb_lumi_tx.sv */
/*
 * LUMI transmit testbench
 * Clock, reset, channel stimulus and PHY-side byte collector
 * Expected byte streams from the length rule and checking assertions
 */
module tb_lumi_tx;

   logic                          clk;
   logic                          nreset;
   logic                          csr_en;
   logic                          csr_crdt_en;
   logic [7:0]                    csr_iowidth;
   lumi_pkg::crdt_t               csr_crdt_intrvl;
   logic [2*lumi_pkg::crdt_w-1:0] csr_crdt_status;
   logic                          req_valid;
   logic [lumi_pkg::cw-1:0]       req_cmd;
   logic [lumi_pkg::aw-1:0]       req_dstaddr;
   logic [lumi_pkg::aw-1:0]       req_srcaddr;
   logic [lumi_pkg::dw-1:0]       req_data;
   logic                          req_ready;
   logic                          resp_valid;
   logic [lumi_pkg::cw-1:0]       resp_cmd;
   logic [lumi_pkg::aw-1:0]       resp_dstaddr;
   logic [lumi_pkg::aw-1:0]       resp_srcaddr;
   logic [lumi_pkg::dw-1:0]       resp_data;
   logic                          resp_ready;
   logic [lumi_pkg::iow-1:0]      phy_txdata;
   logic                          phy_txvld;
   logic                          phy_txrdy;
   lumi_pkg::crdt_t               rmt_crdt_req;
   lumi_pkg::crdt_t               rmt_crdt_resp;
   lumi_pkg::crdt_t               loc_crdt_req;
   lumi_pkg::crdt_t               loc_crdt_resp;

   logic [7:0]      rx_q[$];      // Bytes seen on the lane
   logic [7:0]      exp_q[$];
   bit              care_q[$];    // Zero for padding in a last beat
   int              run_beats;    // Latest unbroken run of beats
   bit              prev_vld;
   int              errors;
   int              tests;
   int              passed;
   int              err_mark;     // Error count at test start
   integer          seed;
   lumi_pkg::crdt_t req_beats;    // Request beats sent so far
   lumi_pkg::crdt_t status_before;
   time             req_acc_time;
   time             resp_acc_time;
   logic            accepted;

   lumi_tx uut (
      .clk          (clk),          .nreset          (nreset),
      .csr_en       (csr_en),       .csr_crdt_en     (csr_crdt_en),
      .csr_iowidth  (csr_iowidth),  .csr_crdt_intrvl (csr_crdt_intrvl),
      .csr_crdt_status(csr_crdt_status),
      .req_valid    (req_valid),    .req_cmd         (req_cmd),
      .req_dstaddr  (req_dstaddr),  .req_srcaddr     (req_srcaddr),
      .req_data     (req_data),     .req_ready       (req_ready),
      .resp_valid   (resp_valid),   .resp_cmd        (resp_cmd),
      .resp_dstaddr (resp_dstaddr), .resp_srcaddr    (resp_srcaddr),
      .resp_data    (resp_data),    .resp_ready      (resp_ready),
      .phy_txdata   (phy_txdata),   .phy_txvld       (phy_txvld),
      .phy_txrdy    (phy_txrdy),    .rmt_crdt_req    (rmt_crdt_req),
      .rmt_crdt_resp(rmt_crdt_resp), .loc_crdt_req   (loc_crdt_req),
      .loc_crdt_resp(loc_crdt_resp)
   );

   always #5 clk = ~clk;

   // ################################################
   // Lane collector and protocol assertions
   // ################################################
   always @(posedge clk)
   begin : collect
      int k;
      if (nreset && phy_txvld)
      begin
         for (k = 0; k < int'(csr_iowidth); k++)
            rx_q.push_back(phy_txdata[8*k +: 8]);   // Low lanes only
         run_beats = prev_vld ? run_beats + 1 : 1;
      end
      prev_vld = nreset && phy_txvld;
   end

   assign accepted = (req_valid && req_ready) || (resp_valid && resp_ready);

   // First beat one cycle after acceptance
   a_first_beat: assert property (@(posedge clk) disable iff (!nreset) accepted |=> phy_txvld)
      else
      begin
         $display("Mismatch at %0t: no beat after an accepted packet", $time);
         errors = errors + 1;
      end

   a_resp_wins: assert property (@(posedge clk) disable iff (!nreset)
      (resp_valid && resp_ready) |-> !req_ready)
      else
      begin
         $display("Mismatch at %0t: request ready next to a response", $time);
         errors = errors + 1;
      end

   // ################################################
   // Expected streams
   // ################################################
   function automatic int beats_for(input int bytes, input int w);
      return (bytes + w - 1) / w;
   endfunction

   function automatic int expected_len(input logic [31:0] cmd);
      int payload;
      payload = (int'(cmd[23:16]) + 1) << cmd[10:8];   // (len+1) << size
      if (payload > 16)
         payload = 16;
      if (cmd[7:0] inside {lumi_pkg::op_invalid, lumi_pkg::op_link})
         return 4;
      if (cmd[7:0] inside {lumi_pkg::op_read, lumi_pkg::op_rdma, lumi_pkg::op_error,
                           lumi_pkg::op_write_resp, lumi_pkg::op_user0, lumi_pkg::op_future0})
         return 20;
      return 20 + payload;
   endfunction

   function automatic logic [31:0] make_cmd(input logic [7:0] op, input logic [7:0] len,
                                            input logic [2:0] size);
      return {8'h00, len, 5'b00000, size, op};
   endfunction

   task automatic push_expected(input bit is_req, input logic [31:0] cmd,
                                input logic [63:0] dst, input logic [63:0] src,
                                input logic [127:0] data);
      logic [287:0] pkt;
      int           len;
      int           k;
      pkt = {data, src, dst, cmd};     // LSB first on the lane
      len = expected_len(cmd);
      for (k = 0; k < len; k++)
      begin
         exp_q.push_back(pkt[8*k +: 8]);
         care_q.push_back(1'b1);
      end
      for (k = len; (k % int'(csr_iowidth)) != 0; k++)
      begin
         exp_q.push_back(8'h00);       // Tail of the last beat
         care_q.push_back(1'b0);
      end
      if (is_req)
         req_beats = req_beats + 16'(beats_for(len, int'(csr_iowidth)));
   endtask

   // ################################################
   // Stimulus tasks
   // ################################################
   task automatic next_drive();
      @(posedge clk);
      #1;
   endtask

   task automatic set_payload(input bit is_resp, input logic [31:0] cmd);
      if (is_resp)
      begin
         resp_cmd     = cmd;
         resp_dstaddr = {$random(seed), $random(seed)};
         resp_srcaddr = {$random(seed), $random(seed)};
         resp_data    = {$random(seed), $random(seed), $random(seed), $random(seed)};
      end
      else
      begin
         req_cmd     = cmd;
         req_dstaddr = {$random(seed), $random(seed)};
         req_srcaddr = {$random(seed), $random(seed)};
         req_data    = {$random(seed), $random(seed), $random(seed), $random(seed)};
      end
   endtask

   // Holds valid until ready on each channel
   task automatic wait_accept(input bit want_req, input bit want_resp);
      int t;
      bit got_req;
      bit got_resp;
      t        = 0;
      got_req  = !want_req;
      got_resp = !want_resp;
      while (!(got_req && got_resp) && t < 100)
      begin
         @(posedge clk);
         t++;
         if (want_req && !got_req && req_valid && req_ready)
         begin
            got_req      = 1'b1;
            req_acc_time = $time;
         end
         if (want_resp && !got_resp && resp_valid && resp_ready)
         begin
            got_resp      = 1'b1;
            resp_acc_time = $time;
         end
         #1;
         if (got_req)
            req_valid = 1'b0;
         if (got_resp)
            resp_valid = 1'b0;
      end
      if (!(got_req && got_resp))
      begin
         $display("Timeout at %0t: input channel never accepted the packet", $time);
         errors    = errors + 1;
         req_valid  = 1'b0;
         resp_valid = 1'b0;
      end
   endtask

   task automatic send_req();
      push_expected(1'b1, req_cmd, req_dstaddr, req_srcaddr, req_data);
      req_valid = 1'b1;
      wait_accept(1'b1, 1'b0);
   endtask

   // Waits for the lane to drain and compares byte by byte
   task automatic check_stream();
      int         t;
      int         idx;
      logic [7:0] got;
      logic [7:0] want;
      bit         care;
      t = 0;
      while ((rx_q.size() < exp_q.size() || phy_txvld) && t < 200)
      begin
         @(negedge clk);
         t++;
      end
      if (t >= 200)
      begin
         $display("Timeout at %0t: lane did not deliver the expected bytes", $time);
         errors = errors + 1;
      end
      assert (rx_q.size() == exp_q.size())
      else
      begin
         $display("Mismatch at %0t: %0d bytes received, %0d expected", $time, rx_q.size(),
                  exp_q.size());
         errors = errors + 1;
      end
      idx = 0;
      while (rx_q.size() > 0 && exp_q.size() > 0)
      begin
         got  = rx_q.pop_front();
         want = exp_q.pop_front();
         care = care_q.pop_front();
         assert (!care || got == want)
         else
         begin
            $display("Mismatch at %0t: byte %0d is %h, expected %h", $time, idx, got, want);
            errors = errors + 1;
         end
         idx++;
      end
      rx_q.delete();
      exp_q.delete();
      care_q.delete();
   endtask

   task automatic test_end(input string name);
      tests++;
      if (errors == err_mark)
      begin
         passed++;
         $display("Test %0d %s: pass", tests, name);
      end
      else
         $display("Test %0d %s: fail with %0d errors", tests, name, errors - err_mark);
      err_mark = errors;
   endtask

   // ################################################
   // Test sequence
   // ################################################
   initial
   begin
      seed            = 11;
      errors          = 0;
      tests           = 0;
      passed          = 0;
      err_mark        = 0;
      req_beats       = '0;
      run_beats       = 0;
      prev_vld        = 1'b0;
      clk             = 1'b0;
      nreset          = 1'b0;
      csr_en          = 1'b1;
      csr_crdt_en     = 1'b0;
      csr_iowidth     = 8'd8;
      csr_crdt_intrvl = 16'd12;
      phy_txrdy       = 1'b1;
      req_valid       = 1'b0;
      resp_valid      = 1'b0;
      rmt_crdt_req    = 16'hF000;     // Plenty of credit
      rmt_crdt_resp   = 16'hF000;
      loc_crdt_req    = 16'h3C5A;
      loc_crdt_resp   = 16'hA5C3;
      set_payload(1'b0, 32'h0);
      set_payload(1'b1, 32'h0);
      repeat (8) @(posedge clk);
      #1 nreset = 1'b1;

      // Write with random len and size
      next_drive();
      set_payload(1'b0, make_cmd(lumi_pkg::op_write, 8'($random(seed)), 3'($random(seed))));
      send_req();
      check_stream();
      test_end("random write length");

      // Read then invalid, back to back
      next_drive();
      set_payload(1'b0, make_cmd(lumi_pkg::op_read, 8'd3, 3'd2));
      send_req();
      set_payload(1'b0, make_cmd(lumi_pkg::op_invalid, 8'd7, 3'd1));
      send_req();
      check_stream();
      test_end("read and invalid");

      // Both channels in one cycle
      next_drive();
      set_payload(1'b1, make_cmd(lumi_pkg::op_write_resp, 8'd0, 3'd0));
      set_payload(1'b0, make_cmd(lumi_pkg::op_posted, 8'd0, 3'd2));
      push_expected(1'b0, resp_cmd, resp_dstaddr, resp_srcaddr, resp_data);
      push_expected(1'b1, req_cmd, req_dstaddr, req_srcaddr, req_data);
      req_valid  = 1'b1;
      resp_valid = 1'b1;
      wait_accept(1'b1, 1'b1);
      assert (resp_acc_time < req_acc_time)
      else
      begin
         $display("Mismatch at %0t: request accepted before response", $time);
         errors = errors + 1;
      end
      check_stream();
      test_end("response priority");

      // Request stalled one beat short of credit
      next_drive();
      set_payload(1'b0, make_cmd(lumi_pkg::op_write, 8'd0, 3'd3));   // 28 bytes
      rmt_crdt_req  = req_beats + 16'd3;
      status_before = csr_crdt_status[15:0];
      req_valid     = 1'b1;
      repeat (20)
      begin
         @(posedge clk);
         assert (!req_ready)
         else
         begin
            $display("Mismatch at %0t: request accepted without credit", $time);
            errors = errors + 1;
         end
      end
      assert (csr_crdt_status[15:0] > status_before)
      else
      begin
         $display("Mismatch at %0t: request stall count stayed at %0d", $time,
                  csr_crdt_status[15:0]);
         errors = errors + 1;
      end
      // Responses always had credit, so no response stalls
      assert (csr_crdt_status[31:16] == 16'd0)
      else
      begin
         $display("Mismatch at %0t: response stall count is %0d, expected 0", $time,
                  csr_crdt_status[31:16]);
         errors = errors + 1;
      end
      #1;
      rmt_crdt_req = 16'hF000;
      send_req();
      check_stream();
      test_end("credit stall");

      // Credit-update messages, response first
      next_drive();
      push_expected(1'b0, {loc_crdt_resp, 4'h1, 4'h2, lumi_pkg::op_link}, '0, '0, '0);
      push_expected(1'b0, {loc_crdt_req, 4'h0, 4'h2, lumi_pkg::op_link}, '0, '0, '0);
      csr_crdt_en = 1'b1;
      check_stream();
      next_drive();
      csr_crdt_en = 1'b0;
      test_end("credit messages");

      // Same packet on a 2-byte and an 8-byte lane
      next_drive();
      csr_iowidth = 8'd2;
      set_payload(1'b0, make_cmd(lumi_pkg::op_write, 8'd1, 3'd2));   // 28 bytes
      send_req();
      check_stream();
      assert (run_beats == beats_for(28, 2))
      else
      begin
         $display("Mismatch at %0t: %0d beats on 2-byte lane", $time, run_beats);
         errors = errors + 1;
      end
      next_drive();
      csr_iowidth = 8'd8;
      send_req();
      check_stream();
      assert (run_beats == beats_for(28, 8))
      else
      begin
         $display("Mismatch at %0t: %0d beats on 8-byte lane", $time, run_beats);
         errors = errors + 1;
      end
      test_end("lane width");

      $display("Tests %0d, passed %0d, failed %0d, errors %0d", tests, passed,
               tests - passed, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

/* project.f */
lumi_pkg.sv
lumi_cmd_decode.sv
lumi_tx_credit.sv
lumi_tx_arbiter.sv
lumi_tx_serializer.sv
lumi_tx.sv
tb_lumi_tx.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the LUMI transmit testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_lumi_tx \
   -f project.f -o tb_lumi_tx > build.log 2>&1 ||
{ cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_lumi_tx > sim.log 2>&1
cat sim.log
grep -q "Result: PASSED" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
